// ==== logic/lsu_pkg.sv ====
package lsu_pkg;

  // ******************************************************************
  // Widths and sizes
  // ******************************************************************

  localparam int XLEN      = 32;
  localparam int SEL_W     = XLEN / 8;
  localparam int RAM_WORDS = 256;
  localparam int WB_ADR_W  = 8;

  typedef logic [XLEN-1:0] word_t;

  // ******************************************************************
  // Opcodes and access controls
  // ******************************************************************

  typedef enum logic [3:0] {
    op_alu,
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_sb,
    op_sh,
    op_sw
  } ls_op_e;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word
  } ls_size_e;

  // The write-back value arrives too late for execute, so it is picked here.
  typedef enum logic {
    fwd_none,
    fwd_wb
  } fwd_sel_e;

  typedef struct packed {
    logic       valid;
    ls_op_e     op;
    word_t      addr;
    word_t      store_data;
    fwd_sel_e   fwd;
    logic [4:0] dest;
    logic       dest_valid;
  } mem_req_t;

  typedef struct packed {
    logic       valid;
    logic       load;
    logic       store;
    ls_size_e   size;
    logic       sext;
    logic [1:0] byte_idx;
    word_t      addr;
    word_t      wdata;
    logic [4:0] dest;
    logic       dest_valid;
    logic       fault;
  } ls_ctrl_t;

  // ******************************************************************
  // Wishbone and write-back
  // ******************************************************************

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    word_t               dat;
    logic [SEL_W-1:0]    sel;
  } wb_bus_t;

  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_rsp_t;

  typedef struct packed {
    logic       valid;
    logic [4:0] dest;
    logic       dest_valid;
    word_t      data;
    logic       fault;
  } wb_rec_t;

endpackage

// ==== logic/ls_decode.sv ====
`timescale 1ns/1ns

module ls_decode (
  input  logic              clock,
  input  logic              rst_n,
  input  lsu_pkg::mem_req_t req,
  input  lsu_pkg::word_t    fwd_data,
  input  logic              hold,
  output lsu_pkg::ls_ctrl_t ctrl
);

  lsu_pkg::ls_ctrl_t ctrl_q;
  lsu_pkg::ls_ctrl_t ctrl_d;
  logic              is_load;
  logic              is_store;
  logic              misaligned;

  // Opcode to access size, direction and extension.
  always_comb begin
    is_load     = 1'b0;
    is_store    = 1'b0;
    ctrl_d.size = lsu_pkg::size_word;
    ctrl_d.sext = 1'b0;
    case (req.op)
      lsu_pkg::op_lb: begin
        is_load     = 1'b1;
        ctrl_d.size = lsu_pkg::size_byte;
        ctrl_d.sext = 1'b1;
      end
      lsu_pkg::op_lbu: begin
        is_load     = 1'b1;
        ctrl_d.size = lsu_pkg::size_byte;
      end
      lsu_pkg::op_lh: begin
        is_load     = 1'b1;
        ctrl_d.size = lsu_pkg::size_half;
        ctrl_d.sext = 1'b1;
      end
      lsu_pkg::op_lhu: begin
        is_load     = 1'b1;
        ctrl_d.size = lsu_pkg::size_half;
      end
      lsu_pkg::op_lw: is_load = 1'b1;
      lsu_pkg::op_sb: begin
        is_store    = 1'b1;
        ctrl_d.size = lsu_pkg::size_byte;
      end
      lsu_pkg::op_sh: begin
        is_store    = 1'b1;
        ctrl_d.size = lsu_pkg::size_half;
      end
      lsu_pkg::op_sw: is_store = 1'b1;
      default: ;
    endcase

    misaligned = (ctrl_d.size == lsu_pkg::size_half && req.addr[0]) ||
                 (ctrl_d.size == lsu_pkg::size_word && req.addr[1:0] != 2'b00);

    // A faulting access is kept off the bus and writes no register.
    ctrl_d.fault      = (is_load || is_store) && misaligned;
    ctrl_d.load       = is_load && !misaligned;
    ctrl_d.store      = is_store && !misaligned;
    ctrl_d.valid      = req.valid;
    ctrl_d.byte_idx   = req.addr[1:0];
    ctrl_d.addr       = req.addr;
    ctrl_d.wdata      = (req.fwd == lsu_pkg::fwd_wb) ? fwd_data : req.store_data;
    ctrl_d.dest       = req.dest;
    ctrl_d.dest_valid = req.dest_valid && !ctrl_d.fault;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ctrl_q.valid <= 1'b0;
    end else if (!hold) begin
      ctrl_q <= ctrl_d;
    end
  end

  assign ctrl = ctrl_q;

endmodule

// ==== logic/ls_execute.sv ====
`timescale 1ns/1ns

module ls_execute (
  input  logic              clock,
  input  logic              rst_n,
  input  lsu_pkg::ls_ctrl_t ctrl,
  output lsu_pkg::wb_bus_t  bus,
  input  lsu_pkg::wb_rsp_t  rsp,
  output logic              done,
  output logic              stall
);

  typedef enum logic {
    idle,
    wait_ack
  } state_e;

  state_e                      state;
  lsu_pkg::wb_bus_t            bus_q;
  logic                        mem_op;
  logic                        start;
  logic [4:0]                  lane_bit;
  lsu_pkg::word_t              lane_dat;
  logic [lsu_pkg::SEL_W-1:0]   lane_sel;

  assign mem_op = ctrl.valid && (ctrl.load || ctrl.store);
  assign start  = (state == idle) && mem_op;

  // ******************************************************************
  // Byte lanes, big-endian: index 0 is bits 31..24 and sel bit 3
  // ******************************************************************

  always_comb begin
    lane_bit = {ctrl.byte_idx, 3'b000};
    lane_dat = ctrl.wdata;
    lane_sel = '1;
    case (ctrl.size)
      lsu_pkg::size_byte: begin
        lane_dat                                = '0;
        lane_dat[lsu_pkg::XLEN-1-lane_bit -: 8] = ctrl.wdata[7:0];
        lane_sel                                = 4'b1000 >> ctrl.byte_idx;
      end
      lsu_pkg::size_half: begin
        lane_dat                                 = '0;
        lane_dat[lsu_pkg::XLEN-1-lane_bit -: 16] = ctrl.wdata[15:0];
        lane_sel                                 = 4'b1100 >> ctrl.byte_idx;
      end
      default: ;
    endcase
  end

  // ******************************************************************
  // Wishbone classic master
  // ******************************************************************

  // One cycle per access. All master fields are registered at the start
  // and left alone until the slave acknowledges.
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state     <= idle;
      bus_q.cyc <= 1'b0;
      bus_q.stb <= 1'b0;
      bus_q.we  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            state     <= wait_ack;
            bus_q.cyc <= 1'b1;
            bus_q.stb <= 1'b1;
            bus_q.we  <= ctrl.store;
            bus_q.adr <= ctrl.addr[lsu_pkg::WB_ADR_W+1:2];
            bus_q.dat <= lane_dat;
            bus_q.sel <= lane_sel;
          end
        end
        wait_ack: begin
          if (rsp.ack) begin
            state     <= idle;
            bus_q.cyc <= 1'b0;
            bus_q.stb <= 1'b0;
            bus_q.we  <= 1'b0;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  assign bus  = bus_q;
  assign done = (state == wait_ack) && rsp.ack;

  // Decode must keep its access until the ack arrives; the next one
  // is taken on the same edge that ends the bus cycle.
  assign stall = mem_op && !done;

endmodule

// ==== logic/ls_result.sv ====
`timescale 1ns/1ns

module ls_result (
  input  logic              clock,
  input  logic              rst_n,
  input  lsu_pkg::ls_ctrl_t ctrl,
  input  logic              done,
  input  lsu_pkg::word_t    rdata,
  output lsu_pkg::wb_rec_t  wb
);

  lsu_pkg::wb_rec_t rec_q;
  lsu_pkg::wb_rec_t rec_d;
  lsu_pkg::word_t   load_val;
  logic [4:0]       lane_bit;
  logic [7:0]       lane_b;
  logic [15:0]      lane_h;
  logic             capture;

  // Pick the addressed lane and extend it to a full word.
  always_comb begin
    lane_bit = {ctrl.byte_idx, 3'b000};
    lane_b   = rdata[lsu_pkg::XLEN-1-lane_bit -: 8];
    lane_h   = rdata[lsu_pkg::XLEN-1-lane_bit -: 16];
    case (ctrl.size)
      lsu_pkg::size_byte: load_val = {{24{ctrl.sext & lane_b[7]}}, lane_b};
      lsu_pkg::size_half: load_val = {{16{ctrl.sext & lane_h[15]}}, lane_h};
      default:            load_val = rdata;
    endcase
  end

  always_comb begin
    rec_d.valid      = 1'b1;
    rec_d.dest       = ctrl.dest;
    rec_d.dest_valid = ctrl.dest_valid && !ctrl.store;
    rec_d.data       = ctrl.load ? load_val : ctrl.addr;
    rec_d.fault      = ctrl.fault;
  end

  // Memory accesses finish on the ack; everything else right after decode.
  assign capture = ctrl.valid && ((ctrl.load || ctrl.store) ? done : 1'b1);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rec_q.valid <= 1'b0;
    end else if (capture) begin
      rec_q <= rec_d;
    end else begin
      rec_q.valid <= 1'b0;
    end
  end

  assign wb = rec_q;

endmodule

// ==== logic/data_ram.sv ====
`timescale 1ns/1ns

module data_ram #(
  parameter int unsigned WAIT_STATES = 1
) (
  input  logic             clock,
  input  logic             rst_n,
  input  lsu_pkg::wb_bus_t bus,
  output lsu_pkg::wb_rsp_t rsp
);

  lsu_pkg::word_t mem [lsu_pkg::RAM_WORDS];
  logic [31:0]    wait_cnt;
  logic           ack;

  // ******************************************************************
  // Wait states
  // ******************************************************************

  // The counter runs while the strobe is up and the slave has not answered.
  always_ff @(posedge clock) begin
    if (!rst_n || !bus.stb || ack) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 32'd1;
    end
  end

  assign ack = bus.cyc && bus.stb && (wait_cnt == WAIT_STATES);

  // ******************************************************************
  // Storage
  // ******************************************************************

  always_ff @(posedge clock) begin
    if (ack && bus.we) begin
      for (int i = 0; i < lsu_pkg::SEL_W; i++) begin
        if (bus.sel[i]) begin
          mem[bus.adr][i*8 +: 8] <= bus.dat[i*8 +: 8];
        end
      end
    end
  end

  // Read data only has to be good while ack is high.
  assign rsp.dat = mem[bus.adr];
  assign rsp.ack = ack;

endmodule

// ==== logic/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top #(
  parameter int unsigned WAIT_STATES = 1
) (
  input  logic              clock,
  input  logic              rst_n,
  input  lsu_pkg::mem_req_t req,
  input  lsu_pkg::word_t    fwd_data,
  output logic              stall,
  output lsu_pkg::wb_rec_t  wb
);

  lsu_pkg::ls_ctrl_t ctrl;
  lsu_pkg::wb_bus_t  bus;
  lsu_pkg::wb_rsp_t  rsp;
  logic              done;

  ls_decode i_decode (
    .clock    (clock),
    .rst_n    (rst_n),
    .req      (req),
    .fwd_data (fwd_data),
    .hold     (stall),
    .ctrl     (ctrl)
  );

  ls_execute i_execute (
    .clock (clock),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .bus   (bus),
    .rsp   (rsp),
    .done  (done),
    .stall (stall)
  );

  ls_result i_result (
    .clock (clock),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .done  (done),
    .rdata (rsp.dat),
    .wb    (wb)
  );

  data_ram #(
    .WAIT_STATES (WAIT_STATES)
  ) i_ram (
    .clock (clock),
    .rst_n (rst_n),
    .bus   (bus),
    .rsp   (rsp)
  );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
  parameter int HALF_PERIOD = 4
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

endmodule

// ==== sim/lsu_sva.sv ====
`timescale 1ns/1ns

module lsu_sva (
  input logic              clock,
  input logic              rst_n,
  input lsu_pkg::ls_ctrl_t ctrl,
  input lsu_pkg::wb_bus_t  bus,
  input lsu_pkg::wb_rsp_t  rsp
);

  logic sel_ok;
  int   fail_cnt = 0;

  // Decode holds ctrl for the whole bus cycle, so its size still applies.
  always_comb begin
    case (ctrl.size)
      lsu_pkg::size_byte: sel_ok = (bus.sel == 4'b1000) || (bus.sel == 4'b0100) ||
                                   (bus.sel == 4'b0010) || (bus.sel == 4'b0001);
      lsu_pkg::size_half: sel_ok = (bus.sel == 4'b1100) || (bus.sel == 4'b0011);
      default:            sel_ok = (bus.sel == 4'b1111);
    endcase
  end

  a_stb_cyc: assert property (@(posedge clock) disable iff (!rst_n)
    bus.stb |-> bus.cyc)
    else begin
      fail_cnt++;
      $error("stb is high without cyc");
    end

  a_hold: assert property (@(posedge clock) disable iff (!rst_n)
    bus.stb && !rsp.ack |=> bus.stb && bus.cyc && $stable(bus.we) &&
      $stable(bus.adr) && $stable(bus.dat) && $stable(bus.sel))
    else begin
      fail_cnt++;
      $error("master fields changed before ack");
    end

  a_end: assert property (@(posedge clock) disable iff (!rst_n)
    bus.stb && rsp.ack |=> !bus.stb && !bus.cyc)
    else begin
      fail_cnt++;
      $error("cycle did not end after ack");
    end

  a_sel: assert property (@(posedge clock) disable iff (!rst_n)
    bus.stb |-> sel_ok)
    else begin
      fail_cnt++;
      $error("sel is not legal for the access size");
    end

  a_start: assert property (@(posedge clock) disable iff (!rst_n)
    $rose(bus.cyc) |-> $past(ctrl.valid && (ctrl.load || ctrl.store)))
    else begin
      fail_cnt++;
      $error("bus cycle started without a valid access");
    end

endmodule

bind ls_execute lsu_sva i_sva (
  .clock (clock),
  .rst_n (rst_n),
  .ctrl  (ctrl),
  .bus   (bus),
  .rsp   (rsp)
);

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb #(
  parameter int WAIT_STATES = 2,
  parameter int TIMEOUT     = 64
);

  logic              clock;
  logic              rst_n;
  lsu_pkg::mem_req_t req;
  lsu_pkg::word_t    fwd_data;
  logic              stall;
  lsu_pkg::wb_rec_t  wb;

  lsu_pkg::word_t    shadow [lsu_pkg::RAM_WORDS];
  lsu_pkg::wb_rec_t  exp_q [$];
  string             name_q [$];
  int                value_errs;
  int                timeout_errs;
  int                other_errs;
  int                assert_errs;

  tb_clock i_clock (.clock(clock));

  lsu_top #(.WAIT_STATES(WAIT_STATES)) i_dut (
    .clock    (clock),
    .rst_n    (rst_n),
    .req      (req),
    .fwd_data (fwd_data),
    .stall    (stall),
    .wb       (wb)
  );

  // **********************************************************************
  // Reference model
  // **********************************************************************

  function automatic logic is_store_op(input lsu_pkg::ls_op_e op);
    return (op == lsu_pkg::op_sb) || (op == lsu_pkg::op_sh) || (op == lsu_pkg::op_sw);
  endfunction

  function automatic lsu_pkg::wb_rec_t expect_rec(input lsu_pkg::mem_req_t r);
    lsu_pkg::wb_rec_t rec;
    lsu_pkg::word_t   word;
    logic [7:0]       b;
    logic [15:0]      h;
    logic             bad;
    int               idx;
    idx  = r.addr[1:0];
    word = shadow[(r.addr >> 2) % lsu_pkg::RAM_WORDS];
    b    = word >> (8 * (3 - idx));
    h    = word >> (8 * (2 - idx));
    case (r.op)
      lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: bad = r.addr[0];
      lsu_pkg::op_lw, lsu_pkg::op_sw:                  bad = (idx != 0);
      default:                                         bad = 1'b0;
    endcase
    rec.valid      = 1'b1;
    rec.dest       = r.dest;
    rec.fault      = bad;
    rec.dest_valid = r.dest_valid && !bad && !is_store_op(r.op);
    rec.data       = r.addr;
    if (!bad) begin
      case (r.op)
        lsu_pkg::op_lb:  rec.data = {{24{b[7]}}, b};
        lsu_pkg::op_lbu: rec.data = {24'h0, b};
        lsu_pkg::op_lh:  rec.data = {{16{h[15]}}, h};
        lsu_pkg::op_lhu: rec.data = {16'h0, h};
        lsu_pkg::op_lw:  rec.data = word;
        default: ;
      endcase
    end
    return rec;
  endfunction

  task automatic apply_store(input lsu_pkg::mem_req_t r, input lsu_pkg::word_t f);
    lsu_pkg::word_t data;
    lsu_pkg::word_t mask;
    int             shift;
    int             w;
    w     = (r.addr >> 2) % lsu_pkg::RAM_WORDS;
    data  = (r.fwd == lsu_pkg::fwd_wb) ? f : r.store_data;
    shift = 0;
    mask  = 32'hffff_ffff;
    if (r.op == lsu_pkg::op_sb) begin
      shift = 8 * (3 - r.addr[1:0]);
      mask  = 32'h0000_00ff;
    end else if (r.op == lsu_pkg::op_sh) begin
      shift = 8 * (2 - r.addr[1:0]);
      mask  = 32'h0000_ffff;
    end
    mask      = mask << shift;
    shadow[w] = (shadow[w] & ~mask) | ((data << shift) & mask);
  endtask

  // **********************************************************************
  // Compare tasks
  // **********************************************************************

  task automatic check_rec(input string name, input lsu_pkg::wb_rec_t exp,
                           input lsu_pkg::wb_rec_t act);
    lsu_pkg::wb_rec_t e;
    lsu_pkg::wb_rec_t a;
    e       = exp;
    a       = act;
    e.fault = 1'b0;
    a.fault = 1'b0;
    if (a !== e) begin
      value_errs++;
      $display("Fail %s: expected dest %0d dv %b data %h, actual dest %0d dv %b data %h",
               name, e.dest, e.dest_valid, e.data, a.dest, a.dest_valid, a.data);
    end
  endtask

  task automatic check_fault(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("Fail %s: expected fault %b, actual fault %b", name, exp, act);
    end
  endtask

  task automatic verify_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      value_errs++;
      $display("Fail %s: expected latency %0d, actual latency %0d", name, exp, act);
    end
  endtask

  // Every write-back pulse is matched against the oldest outstanding record.
  always @(negedge clock) begin
    if (rst_n && wb.valid) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("A write-back pulse arrived with no instruction outstanding");
      end else begin
        check_rec(name_q[0], exp_q[0], wb);
        check_fault(name_q[0], exp_q[0].fault, wb.fault);
        void'(exp_q.pop_front());
        void'(name_q.pop_front());
      end
    end
  end

  // **********************************************************************
  // Stimulus
  // **********************************************************************

  function automatic lsu_pkg::mem_req_t make_req(input lsu_pkg::ls_op_e op,
                                                 input lsu_pkg::word_t addr,
                                                 input lsu_pkg::word_t data,
                                                 input lsu_pkg::fwd_sel_e fwd);
    lsu_pkg::mem_req_t r;
    r.valid      = 1'b1;
    r.op         = op;
    r.addr       = addr;
    r.store_data = data;
    r.fwd        = fwd;
    r.dest       = $urandom_range(31, 0);
    r.dest_valid = 1'b1;
    return r;
  endfunction

  task automatic wait_stall_low(input string name);
    int n;
    n = 0;
    @(negedge clock);
    while (stall && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (stall) begin
      timeout_errs++;
      $display("Timeout in %s: stall never went low", name);
    end
  endtask

  // One request at a time; edges are counted from the accepting edge.
  task automatic send(input string name, input lsu_pkg::mem_req_t r, input lsu_pkg::word_t f);
    lsu_pkg::wb_rec_t exp;
    int               edges;
    bit               seen;
    exp = expect_rec(r);
    if (is_store_op(r.op) && !exp.fault) begin
      apply_store(r, f);
    end
    exp_q.push_back(exp);
    name_q.push_back(name);
    @(posedge clock);
    req      <= r;
    fwd_data <= f;
    wait_stall_low(name);
    @(posedge clock);
    req.valid <= 1'b0;
    edges = 1;
    seen  = 1'b0;
    while (!seen && edges <= TIMEOUT) begin
      @(negedge clock);
      if (wb.valid) begin
        seen = 1'b1;
      end else begin
        @(posedge clock);
        edges++;
      end
    end
    if (!seen) begin
      timeout_errs++;
      $display("Timeout in %s: no write-back record arrived", name);
    end else if (r.op == lsu_pkg::op_alu || exp.fault) begin
      verify_latency(name, 2, edges);
    end else begin
      verify_latency(name, 3 + WAIT_STATES, edges);
    end
  endtask

  initial begin
    lsu_pkg::word_t addr;
    lsu_pkg::word_t addrs [$];
    lsu_pkg::word_t words [2];
    lsu_pkg::mem_req_t r;
    int k;
    int w;

    void'($urandom(32'h4a86_50b8));
    value_errs   = 0;
    timeout_errs = 0;
    other_errs   = 0;
    assert_errs  = 0;
    rst_n        = 1'b0;
    req          = '0;
    fwd_data     = '0;
    repeat (8) @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    if (stall !== 1'b0 || wb.valid !== 1'b0) begin
      other_errs++;
      $display("stall or wb.valid is not low after reset");
    end

    for (k = 0; k < 8; k++) begin
      r            = make_req(lsu_pkg::op_alu, $urandom, $urandom, lsu_pkg::fwd_none);
      r.dest_valid = $urandom_range(1, 0);
      send($sformatf("alu %0d", k), r, $urandom);
    end

    for (k = 0; k < 8; k++) begin
      addr = $urandom_range(255, 0) << 2;
      addrs.push_back(addr);
      send($sformatf("sw %0d", k), make_req(lsu_pkg::op_sw, addr, $urandom,
           lsu_pkg::fwd_none), $urandom);
    end
    for (k = 0; k < 8; k++) begin
      send($sformatf("lw %0d", k), make_req(lsu_pkg::op_lw, addrs[k], '0,
           lsu_pkg::fwd_none), $urandom);
    end

    send("lane base", make_req(lsu_pkg::op_sw, 32'h100, 32'h1122_3344, lsu_pkg::fwd_none), 0);
    for (k = 0; k < 4; k++) begin
      send($sformatf("sb lane %0d", k), make_req(lsu_pkg::op_sb, 32'h100 + k, $urandom,
           lsu_pkg::fwd_none), $urandom);
      send($sformatf("sb merge %0d", k), make_req(lsu_pkg::op_lw, 32'h100, '0,
           lsu_pkg::fwd_none), $urandom);
    end
    for (k = 0; k < 4; k += 2) begin
      send($sformatf("sh lane %0d", k), make_req(lsu_pkg::op_sh, 32'h100 + k, $urandom,
           lsu_pkg::fwd_none), $urandom);
      send($sformatf("sh merge %0d", k), make_req(lsu_pkg::op_lw, 32'h100, '0,
           lsu_pkg::fwd_none), $urandom);
    end

    // Bytes with the top bit set and clear show both kinds of extension.
    words[0] = 32'h80ff_7f01;
    words[1] = 32'h7f80_01fe;
    for (w = 0; w < 2; w++) begin
      addr = 32'h200 + 4 * w;
      send("ext word", make_req(lsu_pkg::op_sw, addr, words[w], lsu_pkg::fwd_none), 0);
      for (k = 0; k < 4; k++) begin
        send($sformatf("lb %0d.%0d", w, k), make_req(lsu_pkg::op_lb, addr + k, '0,
             lsu_pkg::fwd_none), $urandom);
        send($sformatf("lbu %0d.%0d", w, k), make_req(lsu_pkg::op_lbu, addr + k, '0,
             lsu_pkg::fwd_none), $urandom);
      end
      for (k = 0; k < 4; k += 2) begin
        send($sformatf("lh %0d.%0d", w, k), make_req(lsu_pkg::op_lh, addr + k, '0,
             lsu_pkg::fwd_none), $urandom);
        send($sformatf("lhu %0d.%0d", w, k), make_req(lsu_pkg::op_lhu, addr + k, '0,
             lsu_pkg::fwd_none), $urandom);
      end
    end

    send("fwd sw", make_req(lsu_pkg::op_sw, 32'h300, 32'hdead_beef, lsu_pkg::fwd_wb),
         32'h5a5a_0f0f);
    send("fwd lw", make_req(lsu_pkg::op_lw, 32'h300, '0, lsu_pkg::fwd_none), $urandom);
    send("fwd sb", make_req(lsu_pkg::op_sb, 32'h302, 32'h11, lsu_pkg::fwd_wb), 32'hc3);
    send("fwd lw2", make_req(lsu_pkg::op_lw, 32'h300, '0, lsu_pkg::fwd_none), $urandom);

    send("mis base", make_req(lsu_pkg::op_sw, 32'h3f0, 32'hcafe_f00d, lsu_pkg::fwd_none), 0);
    send("mis lh", make_req(lsu_pkg::op_lh, 32'h3f1, '0, lsu_pkg::fwd_none), $urandom);
    send("mis lhu", make_req(lsu_pkg::op_lhu, 32'h3f3, '0, lsu_pkg::fwd_none), $urandom);
    send("mis lw", make_req(lsu_pkg::op_lw, 32'h3f2, '0, lsu_pkg::fwd_none), $urandom);
    send("mis sh", make_req(lsu_pkg::op_sh, 32'h3f1, $urandom, lsu_pkg::fwd_none), $urandom);
    send("mis sw", make_req(lsu_pkg::op_sw, 32'h3f3, $urandom, lsu_pkg::fwd_none), $urandom);
    send("mis check", make_req(lsu_pkg::op_lw, 32'h3f0, '0, lsu_pkg::fwd_none), $urandom);

    repeat (4) @(posedge clock);
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%0d write-back records never arrived", exp_q.size());
    end
    assert_errs = i_dut.i_execute.i_sva.fail_cnt;
    $display("Errors: %0d wrong values, %0d timeouts, %0d assertions, %0d other",
             value_errs, timeout_errs, assert_errs, other_errs);
    if (value_errs + timeout_errs + assert_errs + other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== lsu_sub.f ====
logic/lsu_pkg.sv
logic/ls_decode.sv
logic/ls_execute.sv
logic/ls_result.sv
logic/data_ram.sv
logic/lsu_top.sv
sim/tb_clock.sv
sim/lsu_sva.sv
sim/lsu_tb.sv
